// File: verilog/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int NUM_AREGS    = 32;
    localparam int NUM_PREGS    = 64;
    localparam int ROB_DEPTH    = 16;
    localparam int COMMIT_WIDTH = 2;

    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [$clog2(ROB_DEPTH):0]   rob_cnt_t;    // holds 0 to ROB_DEPTH.
    typedef logic [NUM_PREGS-1:0]         preg_mask_t;

    // upper half free, lower half holds the identity mapping.
    localparam preg_mask_t FREE_RESET = {{(NUM_PREGS - NUM_AREGS){1'b1}}, {NUM_AREGS{1'b0}}};

    typedef struct packed {
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        logic  reg_write;
    } rename_req_t;

    typedef struct packed {
        preg_t    ps1;
        preg_t    ps2;
        preg_t    pd;
        preg_t    pd_old;
        rob_idx_t rob_idx;
        logic     has_dest;
    } rename_rsp_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
        preg_t pd;
        preg_t pd_old;
        logic  has_dest;
    } commit_t;

    typedef struct packed {
        rename_req_t req;
        preg_t       pd;
        preg_t       pd_old;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: verilog/spec_rat.sv
`timescale 1ns/1ps
`default_nettype none

module spec_rat (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush,
    input  wire rename_pkg::rename_req_t req,
    input  wire logic                   alloc,
    input  wire rename_pkg::preg_t      pd,
    input  wire rename_pkg::preg_t      arch_map [rename_pkg::NUM_AREGS],
    output rename_pkg::preg_t           ps1,
    output rename_pkg::preg_t           ps2,
    output rename_pkg::preg_t           pd_old
);

    import rename_pkg::*;

    preg_t map_q [NUM_AREGS];

    // reads see the table before this cycle's own write.
    assign ps1    = map_q[req.rs1];
    assign ps2    = map_q[req.rs2];
    assign pd_old = map_q[req.rd];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= preg_t'(i);    // identity.
            end
        end else if (flush) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= arch_map[i];    // already includes this cycle's commits.
            end
        end else if (alloc) begin
            map_q[req.rd] <= pd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/spec_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module spec_free_list (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush,
    input  wire logic                   alloc,
    input  wire rename_pkg::commit_t    commit [rename_pkg::COMMIT_WIDTH],
    input  wire rename_pkg::preg_mask_t arch_free,
    output rename_pkg::preg_t           pd,
    output logic                        empty
);

    import rename_pkg::*;

    preg_mask_t free_q;
    preg_mask_t free_nxt;

    // lowest free index wins.
    always_comb begin
        pd = '0;
        for (int i = NUM_PREGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                pd = preg_t'(i);
            end
        end
    end

    assign empty = ~|free_q;

    always_comb begin
        free_nxt = free_q;
        if (alloc) begin
            free_nxt[pd] = 1'b0;
        end
        // retiring writers give back the mapping they replaced.
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (commit[k].valid && commit[k].has_dest) begin
                free_nxt[commit[k].pd_old] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            free_q <= FREE_RESET;
        end else if (flush) begin
            free_q <= arch_free;
        end else begin
            free_q <= free_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush,
    input  wire logic                   push,
    input  wire rename_pkg::rob_entry_t push_entry,
    input  wire logic                   complete_valid,
    input  wire rename_pkg::rob_idx_t   complete_idx,
    output rename_pkg::rob_idx_t        tail_idx,
    output logic                        full,
    output rename_pkg::commit_t         commit [rename_pkg::COMMIT_WIDTH]
);

    import rename_pkg::*;

    rob_entry_t           mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    rob_cnt_t             count_q;
    rob_cnt_t             n_retire;

    assign tail_idx = tail_q;
    assign full     = (count_q == rob_cnt_t'(ROB_DEPTH));

    always_comb begin
        logic     chain;
        rob_idx_t idx;
        chain    = 1'b1;
        n_retire = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            idx                = head_q + rob_idx_t'(k);
            commit[k].valid    = chain && (count_q > rob_cnt_t'(k)) && done_q[idx];
            commit[k].rd       = mem[idx].req.rd;
            commit[k].pd       = mem[idx].pd;
            commit[k].pd_old   = mem[idx].pd_old;
            commit[k].has_dest = mem[idx].req.reg_write && (mem[idx].req.rd != '0);
            chain              = commit[k].valid;    // stop at first not-done slot.
            n_retire           = n_retire + rob_cnt_t'(commit[k].valid);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_q] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else if (flush) begin
            // commits of this cycle are already out, drop the rest.
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            head_q  <= head_q + rob_idx_t'(n_retire);
            tail_q  <= tail_q + rob_idx_t'(push);
            count_q <= count_q + rob_cnt_t'(push) - n_retire;
            // a strobe to an empty slot is wiped when that slot is pushed.
            if (complete_valid) begin
                done_q[complete_idx] <= 1'b1;
            end
            if (push) begin
                done_q[tail_q] <= 1'b0;    // fresh slot.
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/arch_rat.sv
`timescale 1ns/1ps
`default_nettype none

module arch_rat (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire rename_pkg::commit_t commit [rename_pkg::COMMIT_WIDTH],
    output rename_pkg::preg_t        arch_map [rename_pkg::NUM_AREGS],
    output rename_pkg::preg_mask_t   arch_free
);

    import rename_pkg::*;

    preg_t      map_q   [NUM_AREGS];
    preg_t      map_nxt [NUM_AREGS];
    preg_mask_t free_q;
    preg_mask_t free_nxt;

    always_comb begin
        for (int i = 0; i < NUM_AREGS; i++) begin
            map_nxt[i] = map_q[i];
        end
        free_nxt = free_q;
        // later slot is younger and overwrites.
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (commit[k].valid && commit[k].has_dest) begin
                map_nxt[commit[k].rd] = commit[k].pd;
                free_nxt[commit[k].pd] = 1'b0;
            end
        end
        // frees applied last so they beat a clear of the same register.
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (commit[k].valid && commit[k].has_dest) begin
                free_nxt[commit[k].pd_old] = 1'b1;
            end
        end
    end

    // recovery reads the bypassed next state.
    always_comb begin
        for (int i = 0; i < NUM_AREGS; i++) begin
            arch_map[i] = map_nxt[i];
        end
    end

    assign arch_free = free_nxt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
            free_q <= FREE_RESET;
        end else begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= map_nxt[i];
            end
            free_q <= free_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    req_valid,
    input  wire rename_pkg::rename_req_t req,
    input  wire logic                    complete_valid,
    input  wire rename_pkg::rob_idx_t    complete_idx,
    input  wire logic                    flush,
    output logic                         req_ready,
    output rename_pkg::rename_rsp_t      rsp,
    output rename_pkg::commit_t          commit [rename_pkg::COMMIT_WIDTH]
);

    import rename_pkg::*;

    logic       has_dest;
    logic       fire;
    logic       alloc;
    logic       rob_full;
    logic       fl_empty;
    preg_t      ps1;
    preg_t      ps2;
    preg_t      map_old;
    preg_t      pd_free;
    rob_idx_t   tail_idx;
    rob_entry_t push_entry;
    preg_t      arch_map [NUM_AREGS];
    preg_mask_t arch_free;

    assign has_dest  = req.reg_write && (req.rd != '0);    // x0 is never renamed.
    assign req_ready = !rob_full && !(has_dest && fl_empty) && !flush;
    assign fire      = req_valid && req_ready;
    assign alloc     = fire && has_dest;

    assign rsp.ps1      = ps1;
    assign rsp.ps2      = ps2;
    assign rsp.pd       = has_dest ? pd_free : '0;
    assign rsp.pd_old   = has_dest ? map_old : '0;
    assign rsp.rob_idx  = tail_idx;
    assign rsp.has_dest = has_dest;

    assign push_entry = '{req: req, pd: rsp.pd, pd_old: rsp.pd_old};

    spec_rat spec_rat_i (
        .clk(clk), .rst(rst), .flush(flush), .req(req), .alloc(alloc), .pd(pd_free),
        .arch_map(arch_map), .ps1(ps1), .ps2(ps2), .pd_old(map_old)
    );

    spec_free_list spec_free_list_i (
        .clk(clk), .rst(rst), .flush(flush), .alloc(alloc), .commit(commit),
        .arch_free(arch_free), .pd(pd_free), .empty(fl_empty)
    );

    reorder_buffer reorder_buffer_i (
        .clk(clk), .rst(rst), .flush(flush), .push(fire), .push_entry(push_entry),
        .complete_valid(complete_valid), .complete_idx(complete_idx),
        .tail_idx(tail_idx), .full(rob_full), .commit(commit)
    );

    arch_rat arch_rat_i (
        .clk(clk), .rst(rst), .commit(commit), .arch_map(arch_map), .arch_free(arch_free)
    );

endmodule

`default_nettype wire

// File: dv/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;

    import rename_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 400;

    logic        clk;
    logic        rst;
    logic        req_valid;
    rename_req_t req;
    logic        complete_valid;
    rob_idx_t    complete_idx;
    logic        flush;
    logic        req_ready;
    rename_rsp_t rsp;
    commit_t     commit [COMMIT_WIDTH];

    int seed;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    // reference model.
    preg_t                m_spec_map [NUM_AREGS];
    preg_t                m_arch_map [NUM_AREGS];
    preg_mask_t           m_spec_free;
    preg_mask_t           m_arch_free;
    areg_t                m_rd       [ROB_DEPTH];
    preg_t                m_pd       [ROB_DEPTH];
    preg_t                m_pd_old   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_hd;
    logic [ROB_DEPTH-1:0] m_done;
    rob_idx_t             m_head;
    rob_idx_t             m_tail;
    rob_cnt_t             m_count;

    logic        exp_ready;
    rename_rsp_t exp_rsp;
    commit_t     exp_commit [COMMIT_WIDTH];

    rename_core rename_core_i (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .complete_valid(complete_valid), .complete_idx(complete_idx), .flush(flush),
        .req_ready(req_ready), .rsp(rsp), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic preg_t lowest_free(input preg_mask_t mask);
        preg_t found;
        logic  seen;
        found = '0;
        seen  = 1'b0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            if (mask[i] && !seen) begin
                found = preg_t'(i);
                seen  = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic rename_req_t make_req(input areg_t rd, input areg_t rs1,
                                             input areg_t rs2, input logic wr);
        rename_req_t r;
        r.rd        = rd;
        r.rs1       = rs1;
        r.rs2       = rs2;
        r.reg_write = wr;
        return r;
    endfunction

    function automatic areg_t rand_reg(input int span);
        int unsigned r;
        r = $unsigned($random(seed));
        return areg_t'(r % span);
    endfunction

    always_comb begin
        rob_idx_t second;
        second           = m_head + 1'b1;
        exp_rsp.has_dest = req.reg_write && (req.rd != '0);
        exp_rsp.ps1      = m_spec_map[req.rs1];
        exp_rsp.ps2      = m_spec_map[req.rs2];
        exp_rsp.pd       = exp_rsp.has_dest ? lowest_free(m_spec_free) : '0;
        exp_rsp.pd_old   = exp_rsp.has_dest ? m_spec_map[req.rd] : '0;
        exp_rsp.rob_idx  = m_tail;
        exp_ready        = (m_count < rob_cnt_t'(ROB_DEPTH)) && !flush
                           && !(exp_rsp.has_dest && (m_spec_free == '0));
        exp_commit[0].valid    = (m_count > 0) && m_done[m_head];
        exp_commit[0].rd       = m_rd[m_head];
        exp_commit[0].pd       = m_pd[m_head];
        exp_commit[0].pd_old   = m_pd_old[m_head];
        exp_commit[0].has_dest = m_hd[m_head];
        exp_commit[1].valid    = exp_commit[0].valid && (m_count > 1) && m_done[second];
        exp_commit[1].rd       = m_rd[second];
        exp_commit[1].pd       = m_pd[second];
        exp_commit[1].pd_old   = m_pd_old[second];
        exp_commit[1].has_dest = m_hd[second];
    end

    task automatic reset_model();
        for (int i = 0; i < NUM_AREGS; i++) begin
            m_spec_map[i] = preg_t'(i);
            m_arch_map[i] = preg_t'(i);
        end
        for (int i = 0; i < NUM_PREGS; i++) begin
            m_spec_free[i] = (i >= NUM_AREGS);
        end
        m_arch_free = m_spec_free;
        m_hd        = '0;
        m_done      = '0;
        m_head      = '0;
        m_tail      = '0;
        m_count     = '0;
    endtask

    // model follows the inputs seen just before each edge.
    always @(posedge clk) begin
        logic     take;
        logic     take_hd;
        preg_t    take_pd;
        preg_t    take_old;
        int       n_ret;
        logic     hit;
        rob_idx_t slot;
        if (!rst) begin
            reset_model();
        end else begin
            take     = req_valid && exp_ready;
            take_hd  = exp_rsp.has_dest;
            take_pd  = exp_rsp.pd;
            take_old = exp_rsp.pd_old;
            n_ret    = int'(exp_commit[0].valid) + int'(exp_commit[1].valid);
            hit      = 1'b0;
            for (int j = 0; j < ROB_DEPTH; j++) begin
                if (j < int'(m_count) && (m_head + rob_idx_t'(j)) == complete_idx) begin
                    hit = complete_valid;
                end
            end
            for (int k = 0; k < n_ret; k++) begin
                slot = m_head + rob_idx_t'(k);
                if (m_hd[slot]) begin
                    m_arch_map[m_rd[slot]]  = m_pd[slot];
                    m_arch_free[m_pd[slot]] = 1'b0;
                end
            end
            if (take && take_hd) begin
                m_spec_free[take_pd] = 1'b0;
            end
            for (int k = 0; k < n_ret; k++) begin
                slot = m_head + rob_idx_t'(k);
                if (m_hd[slot]) begin
                    m_arch_free[m_pd_old[slot]] = 1'b1;    // freed beats cleared.
                    m_spec_free[m_pd_old[slot]] = 1'b1;
                end
            end
            if (flush) begin
                for (int i = 0; i < NUM_AREGS; i++) begin
                    m_spec_map[i] = m_arch_map[i];
                end
                m_spec_free = m_arch_free;
                m_done      = '0;
                m_head      = '0;
                m_tail      = '0;
                m_count     = '0;
            end else begin
                if (hit) begin
                    m_done[complete_idx] = 1'b1;
                end
                m_head  = m_head + rob_idx_t'(n_ret);
                m_count = m_count - rob_cnt_t'(n_ret);
                if (take) begin
                    m_rd[m_tail]     = req.rd;
                    m_pd[m_tail]     = take_pd;
                    m_pd_old[m_tail] = take_old;
                    m_hd[m_tail]     = take_hd;
                    m_done[m_tail]   = 1'b0;
                    if (take_hd) begin
                        m_spec_map[req.rd] = take_pd;
                    end
                    m_tail  = m_tail + 1'b1;
                    m_count = m_count + 1'b1;
                end
            end
        end
    end

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic timeout_error(input string what);
        $display("timeout while %s at %0t", what, $time);
        errors++;
    endtask

    assert property (@(negedge clk) disable iff (!rst) req_ready == exp_ready)
        else report_value("req_ready", req_ready, exp_ready);
    assert property (@(negedge clk) disable iff (!rst)
                     (req_valid && exp_ready) |-> (rsp == exp_rsp))
        else report_value("rsp", rsp, exp_rsp);
    assert property (@(negedge clk) disable iff (!rst) commit[0].valid == exp_commit[0].valid)
        else report_value("commit[0].valid", commit[0].valid, exp_commit[0].valid);
    assert property (@(negedge clk) disable iff (!rst) commit[1].valid == exp_commit[1].valid)
        else report_value("commit[1].valid", commit[1].valid, exp_commit[1].valid);
    assert property (@(negedge clk) disable iff (!rst)
                     exp_commit[0].valid |-> (commit[0] == exp_commit[0]))
        else report_value("commit[0]", commit[0], exp_commit[0]);
    assert property (@(negedge clk) disable iff (!rst)
                     exp_commit[1].valid |-> (commit[1] == exp_commit[1]))
        else report_value("commit[1]", commit[1], exp_commit[1]);

    // returns just before the accepting edge, valid left high.
    task automatic send(input rename_req_t r);
        int waited;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!req_ready) begin
            timeout_error("waiting for req_ready");
        end
    endtask

    task automatic idle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // completes open entries in random order until the ROB is empty.
    task automatic complete_and_drain(input int gap_pct);
        int       cycles;
        int       n_open;
        int       pick;
        rob_idx_t open_idx [ROB_DEPTH];
        rob_idx_t slot;
        for (cycles = 0; cycles < DRAIN_LIMIT; cycles++) begin
            @(negedge clk);
            if (m_count == '0) begin
                break;
            end
            n_open = 0;
            for (int j = 0; j < ROB_DEPTH; j++) begin
                slot = m_head + rob_idx_t'(j);
                if (j < int'(m_count) && !m_done[slot]) begin
                    open_idx[n_open] = slot;
                    n_open++;
                end
            end
            pick = int'($unsigned($random(seed)) % 100);
            @(posedge clk);
            if (n_open > 0 && pick >= gap_pct) begin
                complete_valid <= 1'b1;
                complete_idx   <= open_idx[int'($unsigned($random(seed)) % n_open)];
            end else begin
                complete_valid <= 1'b0;
            end
        end
        @(posedge clk);
        complete_valid <= 1'b0;
        if (cycles == DRAIN_LIMIT) begin
            timeout_error("draining the reorder buffer");
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    initial begin
        rob_idx_t first;
        seed           = 32'ha592_180f;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        rst            = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        flush          = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        begin_test();
        for (int i = 0; i < 16; i++) begin
            send(make_req(5'd0, areg_t'(2 * i), areg_t'(2 * i + 1), 1'b0));
        end
        idle();
        complete_and_drain(0);
        for (int i = 1; i <= 4; i++) begin
            send(make_req(areg_t'(i), areg_t'(i), 5'd0, 1'b1));    // pd 32 upward.
        end
        idle();
        complete_and_drain(0);
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 12; i++) begin
            send(make_req(rand_reg(8), rand_reg(8), rand_reg(8), rand_reg(2) != '0));
        end
        send(make_req(5'd0, 5'd3, 5'd4, 1'b1));    // x0 write, no allocation.
        idle();
        complete_and_drain(0);
        end_test("dependencies");

        begin_test();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            send(make_req(rand_reg(32), rand_reg(32), rand_reg(32), rand_reg(4) != '0));
        end
        idle();
        complete_and_drain(40);
        end_test("in-order commit");

        begin_test();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            send(make_req(areg_t'(i + 1), areg_t'(i), areg_t'(i + 2), 1'b1));
        end
        @(posedge clk);
        req <= make_req(5'd20, 5'd1, 5'd2, 1'b1);    // held against a full ROB.
        repeat (4) @(posedge clk);
        req_valid <= 1'b0;
        complete_and_drain(0);
        for (int i = 0; i < 6; i++) begin
            send(make_req(areg_t'(i + 1), areg_t'(i + 7), areg_t'(i + 1), 1'b1));
        end
        idle();
        complete_and_drain(0);
        end_test("backpressure");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            send(make_req(areg_t'(1 + i % 3), areg_t'(i), 5'd0, 1'b1));
        end
        idle();
        @(negedge clk);
        first = m_head;
        @(posedge clk);
        complete_valid <= 1'b1;
        complete_idx   <= first + 1'b1;    // younger first so both retire together.
        @(posedge clk);
        complete_idx   <= first;
        @(posedge clk);
        complete_valid <= 1'b0;
        flush          <= 1'b1;
        req_valid      <= 1'b1;
        req            <= make_req(5'd9, 5'd1, 5'd2, 1'b1);
        @(posedge clk);
        flush     <= 1'b0;
        req_valid <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            send(make_req(5'd0, areg_t'(2 * i), areg_t'(2 * i + 1), 1'b0));
        end
        idle();
        complete_and_drain(0);
        send(make_req(5'd5, 5'd5, 5'd6, 1'b1));
        idle();
        complete_and_drain(0);
        end_test("flush recovery");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/rename_pkg.sv
verilog/spec_rat.sv
verilog/spec_free_list.sv
verilog/reorder_buffer.sv
verilog/arch_rat.sv
verilog/rename_core.sv
dv/rename_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module rename_core_tb -o rename_core_sim > build.log 2>&1 &&
./obj_dir/rename_core_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "All checks passed" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
